// File: fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
    input  logic clk,
    input  logic rst,

    // allocation side, tail of the circular buffer
    output logic                enq_ready,
    input  logic                enq_valid,
    input  rob_pkg::rob_entry_t enq_data,
    output rob_pkg::rob_tag_t   enq_addr,

    // retirement side, head of the circular buffer
    input  logic                deq_ready,
    output logic                deq_valid,
    output rob_pkg::rob_entry_t deq_data,
    output rob_pkg::rob_tag_t   deq_addr,

    // side read ports used by the completion path to fetch an entry by tag
    input  rob_pkg::rob_tag_t   [rob_pkg::N_CPL_PORTS-1:0] rd_addr,
    output rob_pkg::rob_entry_t [rob_pkg::N_CPL_PORTS-1:0] rd_data,

    // side write ports, each one addresses a different entry than the others and the enqueue
    input  logic                [rob_pkg::N_CPL_PORTS-1:0] wr_en,
    input  rob_pkg::rob_tag_t   [rob_pkg::N_CPL_PORTS-1:0] wr_addr,
    input  rob_pkg::rob_entry_t [rob_pkg::N_CPL_PORTS-1:0] wr_data,

    // number of allocated entries not yet dequeued
    output rob_pkg::rob_cnt_t count
);
    import rob_pkg::*;

    // enqueue and dequeue counters, the low bits are the pointers
    rob_cnt_t enq_ctr;
    rob_cnt_t deq_ctr;
    rob_tag_t enq_ptr;
    rob_tag_t deq_ptr;

    // pointer and wrap bit comparisons
    logic eq_msb;
    logic eq_ptr;
    logic fifo_empty;
    logic fifo_full;

    // handshake qualified enqueue and dequeue strobes
    logic enq;
    logic deq;

    // per entry write enables from the enqueue path and from each write port
    logic [ROB_ENTRIES-1:0] enq_we;
    logic [N_CPL_PORTS-1:0][ROB_ENTRIES-1:0] wr_we;
    logic [ROB_ENTRIES-1:0] entry_we;

    // selected input of each entry and the entry storage itself
    rob_entry_t [ROB_ENTRIES-1:0] entry_din;
    rob_entry_t entry_q [ROB_ENTRIES];

    assign enq_ptr = enq_ctr[ROB_PTR_W-1:0];
    assign deq_ptr = deq_ctr[ROB_PTR_W-1:0];

    // equal pointers mean empty when the wrap bits agree and full when they differ
    assign eq_msb = (enq_ctr[ROB_CTR_W-1] == deq_ctr[ROB_CTR_W-1]);
    assign eq_ptr = (enq_ptr == deq_ptr);
    assign fifo_empty = eq_msb & eq_ptr;
    assign fifo_full = ~eq_msb & eq_ptr;

    assign enq_ready = ~fifo_full;
    assign deq_valid = ~fifo_empty;

    assign enq = enq_ready & enq_valid;
    assign deq = deq_ready & deq_valid;

    // both counters advance by one per handshake and wrap naturally at 16
    always_ff @(posedge clk) begin
        if (rst) begin
            enq_ctr <= '0;
            deq_ctr <= '0;
        end else begin
            if (enq) begin
                enq_ctr <= enq_ctr + 1'b1;
            end
            if (deq) begin
                deq_ctr <= deq_ctr + 1'b1;
            end
        end
    end

    // decode the tail pointer into a one-hot enqueue write enable
    always_comb begin
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            enq_we[i] = enq & (enq_ptr == rob_tag_t'(i));
        end
    end

    // decode every write port address into its own one-hot write enable
    always_comb begin
        for (int p = 0; p < N_CPL_PORTS; p++) begin
            for (int i = 0; i < ROB_ENTRIES; i++) begin
                wr_we[p][i] = wr_en[p] & (wr_addr[p] == rob_tag_t'(i));
            end
        end
    end

    // per entry input select
    // the enqueue data is the default and a write port takes over when it hits the entry
    // a free entry is never the target of a completion, so at most one source is active
    always_comb begin
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            entry_we[i] = enq_we[i];
            entry_din[i] = enq_data;
            for (int p = 0; p < N_CPL_PORTS; p++) begin
                if (wr_we[p][i]) begin
                    entry_we[i] = 1'b1;
                    entry_din[i] = wr_data[p];
                end
            end
        end
    end

    // entry registers, loaded only when one of the paths selects them
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_ENTRIES; i++) begin
            if (entry_we[i]) begin
                entry_q[i] <= entry_din[i];
            end
        end
    end

    // head entry as seen by the retire stage
    assign deq_data = entry_q[deq_ptr];

    // read muxes for the completion lookups
    always_comb begin
        for (int p = 0; p < N_CPL_PORTS; p++) begin
            rd_data[p] = entry_q[rd_addr[p]];
        end
    end

    // the tail and head pointers double as the tags of the next allocation and retirement
    assign enq_addr = enq_ptr;
    assign deq_addr = deq_ptr;

    // full width difference so that 8 entries is distinct from 0
    assign count = enq_ctr - deq_ctr;

endmodule

// File: rob_complete.sv
`timescale 1ns/1ps

module rob_complete (
    input  logic clk,
    input  logic rst,

    // completions from the execution units, always accepted
    input  logic              [rob_pkg::N_CPL_PORTS-1:0] cpl_valid,
    input  rob_pkg::cpl_req_t [rob_pkg::N_CPL_PORTS-1:0] cpl_req,

    // lookup of the stored entry by tag
    output rob_pkg::rob_tag_t   [rob_pkg::N_CPL_PORTS-1:0] rd_addr,
    input  rob_pkg::rob_entry_t [rob_pkg::N_CPL_PORTS-1:0] rd_data,

    // write back of the completed entry
    output logic                [rob_pkg::N_CPL_PORTS-1:0] wr_en,
    output rob_pkg::rob_tag_t   [rob_pkg::N_CPL_PORTS-1:0] wr_addr,
    output rob_pkg::rob_entry_t [rob_pkg::N_CPL_PORTS-1:0] wr_data
);
    import rob_pkg::*;

    // stage 1 registers, one slot per port
    logic     [N_CPL_PORTS-1:0] s1_valid;
    cpl_req_t [N_CPL_PORTS-1:0] s1_req;

    // every cycle each port captures whatever is presented
    // a new completion can follow directly behind the one in stage 2
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= '0;
        end else begin
            s1_valid <= cpl_valid;
        end
    end

    // the request payload needs no clear, it is qualified by s1_valid
    always_ff @(posedge clk) begin
        for (int p = 0; p < N_CPL_PORTS; p++) begin
            if (cpl_valid[p]) begin
                s1_req[p] <= cpl_req[p];
            end
        end
    end

    // stage 2 reads the addressed entry and writes it straight back done
    // the destination comes from the stored entry since the completion does not carry it
    // the two ports never target the same tag in one cycle, so they can run side by side
    always_comb begin
        for (int p = 0; p < N_CPL_PORTS; p++) begin
            rd_addr[p] = s1_req[p].tag;
            wr_en[p] = s1_valid[p];
            wr_addr[p] = s1_req[p].tag;
            wr_data[p].done = 1'b1;
            wr_data[p].dest = rd_data[p].dest;
            wr_data[p].result = s1_req[p].result;
        end
    end

endmodule

// File: rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch (
    input  logic clk,
    input  logic rst,

    // dispatch request from the front end
    input  logic                   dispatch_valid,
    output logic                   dispatch_ready,
    input  rob_pkg::dispatch_req_t dispatch_req,

    // allocation into the entry storage
    output logic                enq_valid,
    input  logic                enq_ready,
    output rob_pkg::rob_entry_t enq_data,
    input  rob_pkg::rob_tag_t   enq_addr,

    // tag assigned to the request that is enqueued in this cycle
    output logic              alloc_valid,
    output rob_pkg::rob_tag_t alloc_tag
);
    import rob_pkg::*;

    // one-entry holding register for an accepted request
    logic          req_valid;
    dispatch_req_t req_q;

    // the held request leaves when the storage has a free entry
    logic drain;

    assign enq_valid = req_valid;
    assign drain = req_valid & enq_ready;

    // a new request fits when the register is empty or empties on this edge
    assign dispatch_ready = ~req_valid | drain;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (dispatch_valid && dispatch_ready) begin
            req_valid <= 1'b1;
        end else if (drain) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid && dispatch_ready) begin
            req_q <= dispatch_req;
        end
    end

    // new entries start not done, the result field is filled in by the completion path
    always_comb begin
        enq_data.done = 1'b0;
        enq_data.dest = req_q.dest;
        enq_data.result = '0;
    end

    // the allocated tag is the tail pointer at the moment of enqueue
    assign alloc_valid = drain;
    assign alloc_tag = enq_addr;

endmodule

// File: rob_pkg.sv
package rob_pkg;

    // ROB geometry, one entry per in-flight instruction
    localparam int ROB_ENTRIES = 8;
    localparam int ROB_PTR_W = 3;

    // counters carry one extra bit so that a full ROB is not mistaken for an empty one
    localparam int ROB_CTR_W = 4;

    // number of completion ports, each with its own read and write port into the storage
    localparam int N_CPL_PORTS = 2;

    // payload widths
    localparam int DATA_W = 32;
    localparam int AREG_W = 5;

    // index of one ROB entry, also used as the instruction's tag
    typedef logic [ROB_PTR_W-1:0] rob_tag_t;

    // occupancy from 0 up to ROB_ENTRIES inclusive
    typedef logic [ROB_CTR_W-1:0] rob_cnt_t;

    // result word written back by a completion
    typedef logic [DATA_W-1:0] data_t;

    // architectural destination register index
    typedef logic [AREG_W-1:0] areg_t;

    // one stored ROB entry
    // done is set by the completion path and gates retirement of the head
    typedef struct packed {
        logic  done;
        areg_t dest;
        data_t result;
    } rob_entry_t;

    // request accepted at dispatch, only the destination is known at this point
    typedef struct packed {
        areg_t dest;
    } dispatch_req_t;

    // result delivered by an execution unit, addressed by ROB tag
    typedef struct packed {
        rob_tag_t tag;
        data_t    result;
    } cpl_req_t;

    // instruction leaving the ROB in program order
    typedef struct packed {
        rob_tag_t tag;
        areg_t    dest;
        data_t    result;
    } retire_t;

endpackage

// File: rob_retire.sv
`timescale 1ns/1ps

module rob_retire (
    input  logic clk,
    input  logic rst,

    // head of the entry storage
    input  logic                deq_valid,
    output logic                deq_ready,
    input  rob_pkg::rob_entry_t deq_data,
    input  rob_pkg::rob_tag_t   deq_addr,

    // retire port towards the architectural state
    output logic              retire_valid,
    input  logic              retire_ready,
    output rob_pkg::retire_t  retire_out
);
    import rob_pkg::*;

    // retire output register
    logic    out_valid;
    retire_t out_q;

    // the output register can take a new item when it is empty or being drained
    logic out_free;

    assign out_free = ~out_valid | retire_ready;

    // only a completed head may leave, which keeps retirement in tag order
    assign deq_ready = deq_valid & deq_data.done & out_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (deq_ready) begin
            out_valid <= 1'b1;
        end else if (retire_ready) begin
            out_valid <= 1'b0;
        end
    end

    // the payload changes only on a dequeue, so it stays put under back-pressure
    always_ff @(posedge clk) begin
        if (deq_ready) begin
            out_q.tag <= deq_addr;
            out_q.dest <= deq_data.dest;
            out_q.result <= deq_data.result;
        end
    end

    assign retire_valid = out_valid;
    assign retire_out = out_q;

endmodule

// File: rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic clk,
    input  logic rst,

    // dispatch port
    input  logic                   dispatch_valid,
    output logic                   dispatch_ready,
    input  rob_pkg::dispatch_req_t dispatch_req,

    // tag reported for each allocation
    output logic              alloc_valid,
    output rob_pkg::rob_tag_t alloc_tag,

    // completion ports, no back-pressure
    input  logic              [rob_pkg::N_CPL_PORTS-1:0] cpl_valid,
    input  rob_pkg::cpl_req_t [rob_pkg::N_CPL_PORTS-1:0] cpl_req,

    // retire port
    output logic             retire_valid,
    input  logic             retire_ready,
    output rob_pkg::retire_t retire_out,

    // occupancy
    output rob_pkg::rob_cnt_t rob_count
);
    import rob_pkg::*;

    // dispatch to storage
    logic       enq_valid;
    logic       enq_ready;
    rob_entry_t enq_data;
    rob_tag_t   enq_addr;

    // storage to retire
    logic       deq_valid;
    logic       deq_ready;
    rob_entry_t deq_data;
    rob_tag_t   deq_addr;

    // completion lookups and write backs
    rob_tag_t   [N_CPL_PORTS-1:0] rd_addr;
    rob_entry_t [N_CPL_PORTS-1:0] rd_data;
    logic       [N_CPL_PORTS-1:0] wr_en;
    rob_tag_t   [N_CPL_PORTS-1:0] wr_addr;
    rob_entry_t [N_CPL_PORTS-1:0] wr_data;

    rob_dispatch dispatch_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_req   (dispatch_req),
        .enq_valid      (enq_valid),
        .enq_ready      (enq_ready),
        .enq_data       (enq_data),
        .enq_addr       (enq_addr),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag)
    );

    fifo_ram fifo_ram_i (
        .clk       (clk),
        .rst       (rst),
        .enq_ready (enq_ready),
        .enq_valid (enq_valid),
        .enq_data  (enq_data),
        .enq_addr  (enq_addr),
        .deq_ready (deq_ready),
        .deq_valid (deq_valid),
        .deq_data  (deq_data),
        .deq_addr  (deq_addr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .count     (rob_count)
    );

    rob_complete complete_i (
        .clk       (clk),
        .rst       (rst),
        .cpl_valid (cpl_valid),
        .cpl_req   (cpl_req),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    rob_retire retire_i (
        .clk          (clk),
        .rst          (rst),
        .deq_valid    (deq_valid),
        .deq_ready    (deq_ready),
        .deq_data     (deq_data),
        .deq_addr     (deq_addr),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_out   (retire_out)
    );

endmodule

// File: run.sh
#!/bin/sh
# build the ROB with its testbench, run it and keep the output in sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rob -f tb.f -o tb_rob \
    && ./obj_dir/tb_rob > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
# a failure message anywhere in the log fails the run
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: tb.f
rob_pkg.sv
fifo_ram.sv
rob_dispatch.sv
rob_complete.sv
rob_retire.sv
rob_top.sv
tb_rob.sv

// File: tb_rob.sv
`timescale 1ns/1ps

module tb_rob;
    import rob_pkg::*;

    // cycle budget of each test
    // the watchdog allows twice the sum of all budgets
    localparam int RESET_CYCLES = 8;
    localparam int FILL_CYCLES = 40;
    localparam int OOO_CYCLES = 40;
    localparam int DUAL_CYCLES = 30;
    localparam int STALL_CYCLES = 40;
    localparam int STRESS_CYCLES = 300;
    localparam int DRAIN_CYCLES = 100;
    localparam int BUDGET_CYCLES = RESET_CYCLES + FILL_CYCLES + OOO_CYCLES + DUAL_CYCLES
        + STALL_CYCLES + STRESS_CYCLES + DRAIN_CYCLES;

    // one instruction of the model on its way from allocation to retirement
    typedef struct packed {
        retire_t item;
        logic    done;
        int      cpl_cyc;
    } model_entry_t;

    logic                       clk;
    logic                       rst;
    logic                       dispatch_valid;
    logic                       dispatch_ready;
    dispatch_req_t              dispatch_req;
    logic                       alloc_valid;
    rob_tag_t                   alloc_tag;
    logic [N_CPL_PORTS-1:0]     cpl_valid;
    cpl_req_t [N_CPL_PORTS-1:0] cpl_req;
    logic                       retire_valid;
    logic                       retire_ready;
    retire_t                    retire_out;
    rob_cnt_t                   rob_count;

    integer seed;
    int errors;
    int cyc;
    int disp_cnt;
    int alloc_cnt;
    int retire_cnt;
    rob_tag_t exp_tag;

    // number of entries that the model expects to have left the storage
    int deq_cnt;

    // model of the dispatch holding register and of the retire output register
    logic req_held;
    logic out_busy;

    // dests accepted at dispatch that still wait for an entry
    areg_t dest_q[$];
    // program order model of the allocated instructions
    model_entry_t model_q[$];
    // allocated tags that still wait for a completion
    rob_tag_t pending[$];

    rob_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_req   (dispatch_req),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .cpl_valid      (cpl_valid),
        .cpl_req        (cpl_req),
        .retire_valid   (retire_valid),
        .retire_ready   (retire_ready),
        .retire_out     (retire_out),
        .rob_count      (rob_count)
    );

    always #50 clk = ~clk;

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (exp == act) else begin
            $display("MISMATCH %0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // the model steps at every rising edge on the values that lead up to it
    always @(posedge clk) begin
        model_entry_t head;
        logic found;
        int head_idx;
        logic exp_alloc;
        logic exp_ready;
        logic exp_deq;
        if (!rst) begin
            // the held request is enqueued whenever the storage has a free entry
            exp_alloc = req_held && (alloc_cnt - deq_cnt < ROB_ENTRIES);
            exp_ready = !req_held || exp_alloc;
            compare_field("alloc_valid", exp_alloc, alloc_valid);
            compare_field("dispatch_ready", exp_ready, dispatch_ready);
            compare_field("retire_valid", out_busy, retire_valid);
            compare_field("rob_count", alloc_cnt - deq_cnt, rob_count);
            // the oldest entry still in the storage comes after the one in the retire register
            // its done bit reaches the storage two edges after the completion
            head_idx = out_busy ? 1 : 0;
            exp_deq = model_q.size() > head_idx && model_q[head_idx].done
                && cyc - model_q[head_idx].cpl_cyc >= 2 && (!out_busy || retire_ready);
            if (retire_valid && retire_ready) begin
                assert (model_q.size() != 0) else begin
                    $display("%0t: retirement while the model holds no instruction", $time);
                    errors++;
                end
                if (model_q.size() != 0) begin
                    head = model_q.pop_front();
                    compare_field("retire_out.tag", head.item.tag, retire_out.tag);
                    compare_field("retire_out.dest", head.item.dest, retire_out.dest);
                    compare_field("retire_out.result", head.item.result, retire_out.result);
                    // done reaches the storage on the second edge and the retire port on the third
                    assert (head.done && cyc - head.cpl_cyc >= 3) else begin
                        $display("%0t: tag %0d retired before it was done", $time,
                                 head.item.tag);
                        errors++;
                    end
                end
                retire_cnt++;
            end
            if (exp_deq) begin
                out_busy = 1'b1;
                deq_cnt++;
            end else if (retire_ready) begin
                out_busy = 1'b0;
            end
            // a completion hits the one not yet done instance of its tag
            for (int p = 0; p < N_CPL_PORTS; p++) begin
                found = 1'b0;
                foreach (model_q[i]) begin
                    if (cpl_valid[p] && !found && !model_q[i].done
                            && model_q[i].item.tag == cpl_req[p].tag) begin
                        model_q[i].done = 1'b1;
                        model_q[i].item.result = cpl_req[p].result;
                        model_q[i].cpl_cyc = cyc;
                        found = 1'b1;
                    end
                end
            end
            if (exp_alloc) begin
                compare_field("alloc_tag", exp_tag, alloc_tag);
                head = '0;
                head.item.tag = exp_tag;
                head.item.dest = dest_q.pop_front();
                model_q.push_back(head);
                pending.push_back(exp_tag);
                exp_tag = exp_tag + 1'b1;
                alloc_cnt++;
            end
            if (dispatch_valid && exp_ready) begin
                dest_q.push_back(dispatch_req.dest);
                disp_cnt++;
                req_held = 1'b1;
            end else if (exp_alloc) begin
                req_held = 1'b0;
            end
        end
        cyc++;
    end

    function automatic rob_tag_t take_pending();
        int idx;
        rob_tag_t tag;
        idx = $unsigned($random(seed)) % pending.size();
        tag = pending[idx];
        pending.delete(idx);
        return tag;
    endfunction

    // drives one cycle of completions with a distinct random pending tag on each port
    task automatic complete_some(input int n_ports, input bit every_cycle);
        for (int p = 0; p < N_CPL_PORTS; p++) begin
            cpl_valid[p] = 1'b0;
            if (p < n_ports && pending.size() != 0
                    && (every_cycle || ($random(seed) & 1) != 0)) begin
                cpl_valid[p] = 1'b1;
                cpl_req[p].tag = take_pending();
                cpl_req[p].result = $random(seed);
            end
        end
    endtask

    // starts at a falling edge and returns at the falling edge after the handshake
    task automatic dispatch_one(input areg_t dest);
        dispatch_valid = 1'b1;
        dispatch_req.dest = dest;
        @(posedge clk);
        while (!dispatch_ready) @(posedge clk);
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_allocated(input int n);
        while (alloc_cnt < n) @(negedge clk);
    endtask

    task automatic check_reset_state();
        compare_field("alloc_valid", 0, alloc_valid);
        compare_field("retire_valid", 0, retire_valid);
        compare_field("dispatch_ready", 1, dispatch_ready);
        compare_field("rob_count", 0, rob_count);
    endtask

    // eight allocations fill the ROB and the ninth request waits in the dispatch register
    task automatic fill_to_full();
        retire_ready = 1'b1;
        for (int i = 0; i <= ROB_ENTRIES; i++) begin
            dispatch_one(areg_t'($random(seed)));
        end
        wait_allocated(ROB_ENTRIES);
        repeat (4) begin
            compare_field("dispatch_ready", 0, dispatch_ready);
            compare_field("alloc_valid", 0, alloc_valid);
            compare_field("rob_count", ROB_ENTRIES, rob_count);
            @(negedge clk);
        end
    endtask

    // one completion per cycle in random tag order while retirement keeps to tag order
    task automatic retire_out_of_order();
        while (retire_cnt < ROB_ENTRIES) begin
            complete_some(1, 1'b1);
            @(negedge clk);
        end
        cpl_valid = '0;
    endtask

    task automatic complete_dual_port();
        repeat (4) dispatch_one(areg_t'($random(seed)));
        wait_allocated(disp_cnt);
        while (retire_cnt != alloc_cnt) begin
            complete_some(2, 1'b1);
            @(negedge clk);
        end
        cpl_valid = '0;
    endtask

    // with retire_ready low the output register and the occupancy have to freeze
    task automatic stall_retire();
        retire_t held;
        rob_cnt_t held_count;
        retire_ready = 1'b0;
        repeat (3) dispatch_one(areg_t'($random(seed)));
        wait_allocated(disp_cnt);
        while (pending.size() != 0) begin
            complete_some(2, 1'b1);
            @(negedge clk);
        end
        cpl_valid = '0;
        while (!retire_valid) @(negedge clk);
        held = retire_out;
        held_count = rob_count;
        repeat (6) begin
            @(negedge clk);
            compare_field("retire_valid", 1, retire_valid);
            compare_field("retire_out", held, retire_out);
            compare_field("rob_count", held_count, rob_count);
        end
        retire_ready = 1'b1;
        while (retire_cnt != alloc_cnt) @(negedge clk);
    endtask

    task automatic stress_wraparound();
        int disp_seen;
        int start_retired;
        disp_seen = disp_cnt;
        start_retired = retire_cnt;
        for (int c = 0; c < STRESS_CYCLES; c++) begin
            // a request stays on the bus until it has been taken
            if (!dispatch_valid || disp_cnt != disp_seen) begin
                disp_seen = disp_cnt;
                dispatch_valid = ($random(seed) & 1) != 0;
                dispatch_req.dest = areg_t'($random(seed));
            end
            retire_ready = ($random(seed) & 3) != 0;
            complete_some(2, 1'b0);
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
        retire_ready = 1'b1;
        while (retire_cnt != disp_cnt) begin
            complete_some(2, 1'b1);
            @(negedge clk);
        end
        cpl_valid = '0;
        compare_field("rob_count", 0, rob_count);
        assert (retire_cnt - start_retired > 3 * ROB_ENTRIES) else begin
            $display("stress run retired only %0d instructions", retire_cnt - start_retired);
            errors++;
        end
    endtask

    initial begin
        seed = 32'h1dbd;
        errors = 0;
        cyc = 0;
        disp_cnt = 0;
        alloc_cnt = 0;
        retire_cnt = 0;
        deq_cnt = 0;
        req_held = 1'b0;
        out_busy = 1'b0;
        exp_tag = '0;
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_req = '0;
        cpl_valid = '0;
        cpl_req = '0;
        retire_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        fill_to_full();
        retire_out_of_order();
        complete_dual_port();
        stall_retire();
        stress_wraparound();
        $display("tests done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(BUDGET_CYCLES * 100 * 2);
        $display("watchdog expired, the tests did not finish in %0d cycles", 2 * BUDGET_CYCLES);
        $display("errors: %0d", errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
